/* common/axi_rd_consts.svh */
// AXI read slice widths
`ifndef AXI_RD_CONSTS_SVH
`define AXI_RD_CONSTS_SVH

// transaction id carried on ar and r
// must match between master and slave sides
`define AXI_ID_WIDTH 8

// byte address of the first beat of a burst
`define AXI_ADDR_WIDTH 32

// read data bus
// one beat per r transfer
`define AXI_DATA_WIDTH 32

// burst length field, beats minus one
// full AXI4 range of 256 beats
`define AXI_LEN_WIDTH 8

// the remaining ar fields have fixed widths from the AXI4 spec
// size 3, lock 1, cache 4, prot 3, qos 4, region 4
// and are written out directly in the beat structs

// both channel slices take their payload width from these
// through the structs in the package

`endif

/* common/axi_rd_pkg.sv */
// AXI read channel types
`default_nettype none

`include "axi_rd_consts.svh"

package axi_rd_pkg;

    // arburst encoding
    // 2'b11 is reserved in AXI4
    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10
    } axi_burst_e;

    // rresp encoding
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } axi_resp_e;

    // one read address beat, id in the top bits
    typedef struct packed {
        logic [`AXI_ID_WIDTH-1:0]   id;
        logic [`AXI_ADDR_WIDTH-1:0] addr;
        logic [`AXI_LEN_WIDTH-1:0]  len;
        logic [2:0]                 size;
        axi_burst_e                 burst;
        logic                       lock;
        logic [3:0]                 cache;
        logic [2:0]                 prot;
        logic [3:0]                 qos;
        logic [3:0]                 region;
    } ar_beat_t;

    // one read data beat
    typedef struct packed {
        logic [`AXI_ID_WIDTH-1:0]   id;
        logic [`AXI_DATA_WIDTH-1:0] data;
        axi_resp_e                  resp;
        logic                       last;
    } r_beat_t;

endpackage

`default_nettype wire

/* src/ar_reg_slice.sv */
// AR channel one-entry register
`default_nettype none

module ar_reg_slice
    import axi_rd_pkg::*;
(
    input  wire           clk,
    input  wire           rst,

    // upstream, from the master
    input  wire ar_beat_t s_ar,
    input  wire           s_arvalid,
    output logic          s_arready,

    // downstream, towards the slave
    output ar_beat_t      m_ar,
    output logic          m_arvalid,
    input  wire           m_arready
);

    // output register and its valid flag
    ar_beat_t m_ar_reg;
    logic     m_arvalid_reg;
    logic     m_arvalid_next;

    // registered ready towards the master
    logic s_arready_reg;
    logic s_arready_early;

    // load strobe for the payload register
    logic store_input_to_output;

    assign s_arready = s_arready_reg;
    assign m_ar      = m_ar_reg;
    assign m_arvalid = m_arvalid_reg;

    // next valid state and payload load
    always_comb begin
        m_arvalid_next        = m_arvalid_reg;
        store_input_to_output = 1'b0;

        if (s_arready_reg) begin
            // register is empty here, take whatever the master offers
            m_arvalid_next        = s_arvalid;
            store_input_to_output = 1'b1;
        end else if (m_arready) begin
            // slave took the held beat
            m_arvalid_next = 1'b0;
        end
    end

    // ready only when the register will be empty after this edge
    // a full register therefore always costs one bubble cycle
    assign s_arready_early = ~m_arvalid_next;

    // control state
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s_arready_reg <= 1'b0;
            m_arvalid_reg <= 1'b0;
        end else begin
            s_arready_reg <= s_arready_early;
            m_arvalid_reg <= m_arvalid_next;
        end
    end

    // address beat payload
    always_ff @(posedge clk) begin
        if (store_input_to_output) begin
            m_ar_reg <= s_ar;
        end
    end

endmodule

`default_nettype wire

/* src/r_skid_slice.sv */
// R channel skid buffer
`default_nettype none

module r_skid_slice
    import axi_rd_pkg::*;
(
    input  wire          clk,
    input  wire          rst,

    // upstream, from the slave
    input  wire r_beat_t m_r,
    input  wire          m_rvalid,
    output logic         m_rready,

    // downstream, towards the master
    output r_beat_t      s_r,
    output logic         s_rvalid,
    input  wire          s_rready
);

    // output register
    r_beat_t s_r_reg;
    logic    s_rvalid_reg;
    logic    s_rvalid_next;

    // skid register, catches the beat in flight when the master stalls
    r_beat_t skid_r_reg;
    logic    skid_rvalid_reg;
    logic    skid_rvalid_next;

    // registered ready towards the slave
    logic m_rready_reg;
    logic m_rready_early;

    // datapath moves for this edge
    logic store_input_to_output;
    logic store_input_to_skid;
    logic store_skid_to_output;

    assign m_rready = m_rready_reg;
    assign s_r      = s_r_reg;
    assign s_rvalid = s_rvalid_reg;

    // keep accepting if the master is ready,
    // or if nothing can land in the skid register on this edge
    // (skid empty and either the output is empty or no beat arrives)
    assign m_rready_early = s_rready |
                            (~skid_rvalid_reg & (~s_rvalid_reg | ~m_rvalid));

    always_comb begin
        s_rvalid_next         = s_rvalid_reg;
        skid_rvalid_next      = skid_rvalid_reg;
        store_input_to_output = 1'b0;
        store_input_to_skid   = 1'b0;
        store_skid_to_output  = 1'b0;

        if (m_rready_reg) begin
            if (s_rready | ~s_rvalid_reg) begin
                // output drains or is empty, input goes straight through
                s_rvalid_next         = m_rvalid;
                store_input_to_output = 1'b1;
            end else begin
                // output stalled, park the incoming beat
                skid_rvalid_next    = m_rvalid;
                store_input_to_skid = 1'b1;
            end
        end else if (s_rready) begin
            // input closed, move skid beat forward
            s_rvalid_next        = skid_rvalid_reg;
            skid_rvalid_next     = 1'b0;
            store_skid_to_output = 1'b1;
        end
    end

    // control state
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            m_rready_reg    <= 1'b0;
            s_rvalid_reg    <= 1'b0;
            skid_rvalid_reg <= 1'b0;
        end else begin
            m_rready_reg    <= m_rready_early;
            s_rvalid_reg    <= s_rvalid_next;
            skid_rvalid_reg <= skid_rvalid_next;
        end
    end

    // output payload, from input or from skid
    always_ff @(posedge clk) begin
        if (store_input_to_output) begin
            s_r_reg <= m_r;
        end else if (store_skid_to_output) begin
            s_r_reg <= skid_r_reg;
        end
    end

    // skid payload
    always_ff @(posedge clk) begin
        if (store_input_to_skid) begin
            skid_r_reg <= m_r;
        end
    end

endmodule

`default_nettype wire

/* src/axi_register_rd.sv */
// AXI4 read register slice
`default_nettype none

module axi_register_rd
    import axi_rd_pkg::*;
(
    input  wire           clk,
    input  wire           rst,

    // master side, read address in
    input  wire ar_beat_t s_ar,
    input  wire           s_arvalid,
    output logic          s_arready,

    // master side, read data out
    output r_beat_t       s_r,
    output logic          s_rvalid,
    input  wire           s_rready,

    // slave side, read address out
    output ar_beat_t      m_ar,
    output logic          m_arvalid,
    input  wire           m_arready,

    // slave side, read data in
    input  wire r_beat_t  m_r,
    input  wire           m_rvalid,
    output logic          m_rready
);

    // address channel
    // simple register, one bubble per accepted beat
    ar_reg_slice ar_slice (
        .clk       (clk),
        .rst       (rst),
        .s_ar      (s_ar),
        .s_arvalid (s_arvalid),
        .s_arready (s_arready),
        .m_ar      (m_ar),
        .m_arvalid (m_arvalid),
        .m_arready (m_arready)
    );

    // data channel
    // skid buffer, full rate
    // note the names flip here since r flows from the slave side back to the master
    r_skid_slice r_slice (
        .clk      (clk),
        .rst      (rst),
        .m_r      (m_r),
        .m_rvalid (m_rvalid),
        .m_rready (m_rready),
        .s_r      (s_r),
        .s_rvalid (s_rvalid),
        .s_rready (s_rready)
    );

    // both slices register their own outputs
    // nothing is added between the ports and the instances
    // so the top adds no latency

endmodule

`default_nettype wire

/* tests/tb_axi_register_rd.sv */
// AXI read slice testbench
`default_nettype none

`include "axi_rd_consts.svh"

module tb_axi_register_rd
    import axi_rd_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int BEATS = 64;
    // 4 tests x 64 beats x at most 8 cycles, plus margin
    localparam int TIMEOUT_CYCLES = 6000;

    logic clk = 1'b0;
    logic rst = 1'b1;

    // master side
    ar_beat_t s_ar      = '0;
    logic     s_arvalid = 1'b0;
    logic     s_arready;
    r_beat_t  s_r;
    logic     s_rvalid;
    logic     s_rready  = 1'b0;

    // slave side
    ar_beat_t m_ar;
    logic     m_arvalid;
    logic     m_arready = 1'b0;
    r_beat_t  m_r       = '0;
    logic     m_rvalid  = 1'b0;
    logic     m_rready;

    // model state
    ar_beat_t ar_src_q[$];
    ar_beat_t ar_exp_q[$];
    ar_beat_t ar_obs_q[$];
    r_beat_t  r_src_q[$];
    r_beat_t  r_exp_q[$];
    r_beat_t  r_obs_q[$];

    logic models_on     = 1'b0;
    logic ar_rand_valid = 1'b0;
    logic ar_rand_ready = 1'b0;
    logic r_rand_valid  = 1'b0;
    logic r_rand_ready  = 1'b0;
    logic r_full_check  = 1'b0;

    // monitor state
    logic     ar_fire      = 1'b0;
    logic     ar_fire_last = 1'b0;
    logic     r_fire       = 1'b0;
    logic     ar_stalled   = 1'b0;
    logic     r_stalled    = 1'b0;
    ar_beat_t ar_stalled_beat;
    r_beat_t  r_stalled_beat;

    int cycles      = 0;
    int r_accepts   = 0;
    int r_full_base = 0;
    int errors      = 0;
    int checks      = 0;

    logic [15:0] lfsr_state = 16'd38999;

    axi_register_rd uut (
        .clk       (clk),
        .rst       (rst),
        .s_ar      (s_ar),
        .s_arvalid (s_arvalid),
        .s_arready (s_arready),
        .s_r       (s_r),
        .s_rvalid  (s_rvalid),
        .s_rready  (s_rready),
        .m_ar      (m_ar),
        .m_arvalid (m_arvalid),
        .m_arready (m_arready),
        .m_r       (m_r),
        .m_rvalid  (m_rvalid),
        .m_rready  (m_rready)
    );

    always #2 clk = ~clk;

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        logic        lsb;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lsb        = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (lsb) begin
                lfsr_state = lfsr_state ^ 16'hB400;
            end
            value = {value[30:0], lsb};
        end
        return value;
    endfunction

    function automatic logic random_bit();
        logic [31:0] value;
        value = random_bits(1);
        return value[0];
    endfunction

    task automatic flag_bit_mismatch(input string name, input logic expected,
                                     input logic actual);
        $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
        errors++;
    endtask

    // upstream and downstream models, driven on the falling edge
    always @(negedge clk) begin
        if (models_on) begin
            // master on AR, holds valid until the beat is taken
            if (!s_arvalid || ar_fire) begin
                if (ar_src_q.size() > 0 && (!ar_rand_valid || random_bit())) begin
                    s_ar      = ar_src_q.pop_front();
                    s_arvalid = 1'b1;
                end else begin
                    s_arvalid = 1'b0;
                end
            end
            m_arready = ar_rand_ready ? random_bit() : 1'b1;

            // slave on R
            if (!m_rvalid || r_fire) begin
                if (r_src_q.size() > 0 && (!r_rand_valid || random_bit())) begin
                    m_r      = r_src_q.pop_front();
                    m_rvalid = 1'b1;
                end else begin
                    m_rvalid = 1'b0;
                end
            end
            s_rready = r_rand_ready ? random_bit() : 1'b1;
        end
    end

    // handshake monitor and sinks
    always @(posedge clk) begin
        cycles++;
        ar_fire = s_arvalid && s_arready;
        r_fire  = m_rvalid && m_rready;

        // the AR register needs a bubble after every accept
        if (ar_fire && ar_fire_last) begin
            $display("s_ar was accepted on two consecutive edges at cycle %0d", cycles);
            errors++;
        end
        ar_fire_last = ar_fire;
        if (r_fire) begin
            r_accepts++;
        end

        if (m_arvalid && m_arready) begin
            ar_obs_q.push_back(m_ar);
        end
        if (s_rvalid && s_rready) begin
            r_obs_q.push_back(s_r);
        end

        // a stalled beat stays put until taken
        if (ar_stalled) begin
            if (m_arvalid !== 1'b1) begin
                flag_bit_mismatch("m_arvalid", 1'b1, m_arvalid);
            end else if (m_ar !== ar_stalled_beat) begin
                $display("CHECK FAILED m_ar: expected %h, actual %h", ar_stalled_beat, m_ar);
                errors++;
            end
        end
        ar_stalled      = m_arvalid && !m_arready;
        ar_stalled_beat = m_ar;

        if (r_stalled) begin
            if (s_rvalid !== 1'b1) begin
                flag_bit_mismatch("s_rvalid", 1'b1, s_rvalid);
            end else if (s_r !== r_stalled_beat) begin
                $display("CHECK FAILED s_r: expected %h, actual %h", r_stalled_beat, s_r);
                errors++;
            end
        end
        r_stalled      = s_rvalid && !s_rready;
        r_stalled_beat = s_r;

        if (r_full_check && r_accepts > r_full_base && m_rready !== 1'b1) begin
            flag_bit_mismatch("m_rready", 1'b1, m_rready);
        end
    end

    task automatic check_controls_low;
        if (s_arready !== 1'b0) flag_bit_mismatch("s_arready", 1'b0, s_arready);
        if (m_arvalid !== 1'b0) flag_bit_mismatch("m_arvalid", 1'b0, m_arvalid);
        if (m_rready !== 1'b0) flag_bit_mismatch("m_rready", 1'b0, m_rready);
        if (s_rvalid !== 1'b0) flag_bit_mismatch("s_rvalid", 1'b0, s_rvalid);
    endtask

    task automatic test_reset;
        repeat (8) begin
            @(negedge clk);
            check_controls_low();
        end
        rst = 1'b0;
        // still inside the first cycle after release
        #1;
        check_controls_low();
        repeat (2) @(posedge clk);
        @(negedge clk);
        if (s_arready !== 1'b1) flag_bit_mismatch("s_arready", 1'b1, s_arready);
        if (m_rready !== 1'b1) flag_bit_mismatch("m_rready", 1'b1, m_rready);
        @(posedge clk);
        models_on = 1'b1;
    endtask

    task automatic start_ar_stream(input logic rand_valid, input logic rand_ready);
        ar_beat_t b;
        @(posedge clk);
        ar_rand_valid = rand_valid;
        ar_rand_ready = rand_ready;
        ar_obs_q.delete();
        ar_exp_q.delete();
        for (int i = 0; i < BEATS; i++) begin
            b.id     = `AXI_ID_WIDTH'(random_bits(`AXI_ID_WIDTH));
            b.addr   = `AXI_ADDR_WIDTH'(random_bits(`AXI_ADDR_WIDTH));
            b.len    = `AXI_LEN_WIDTH'(random_bits(`AXI_LEN_WIDTH));
            b.size   = 3'(random_bits(3));
            // reserved burst code left out
            b.burst  = axi_burst_e'(2'(random_bits(2) % 3));
            b.lock   = random_bit();
            b.cache  = 4'(random_bits(4));
            b.prot   = 3'(random_bits(3));
            b.qos    = 4'(random_bits(4));
            b.region = 4'(random_bits(4));
            ar_src_q.push_back(b);
            ar_exp_q.push_back(b);
        end
    endtask

    task automatic start_r_stream(input logic rand_valid, input logic rand_ready);
        r_beat_t b;
        @(posedge clk);
        r_rand_valid = rand_valid;
        r_rand_ready = rand_ready;
        r_obs_q.delete();
        r_exp_q.delete();
        for (int i = 0; i < BEATS; i++) begin
            b.id   = `AXI_ID_WIDTH'(random_bits(`AXI_ID_WIDTH));
            b.data = `AXI_DATA_WIDTH'(random_bits(`AXI_DATA_WIDTH));
            b.resp = axi_resp_e'(2'(random_bits(2)));
            // bursts of four beats
            b.last = (i % 4 == 3);
            r_src_q.push_back(b);
            r_exp_q.push_back(b);
        end
    endtask

    // idle cycles after the last beat catch duplicates
    task automatic wait_ar_drain;
        while (ar_obs_q.size() < BEATS) @(negedge clk);
        repeat (8) @(negedge clk);
        @(posedge clk);
        ar_rand_valid = 1'b0;
        ar_rand_ready = 1'b0;
    endtask

    task automatic wait_r_drain;
        while (r_obs_q.size() < BEATS) @(negedge clk);
        repeat (8) @(negedge clk);
        @(posedge clk);
        r_rand_valid = 1'b0;
        r_rand_ready = 1'b0;
    endtask

    task automatic compare_ar_beats(input string label);
        if (ar_obs_q.size() != ar_exp_q.size()) begin
            $display("%s: slave side took %0d address beats but %0d were sent",
                     label, ar_obs_q.size(), ar_exp_q.size());
            errors++;
        end
        for (int i = 0; i < ar_exp_q.size() && i < ar_obs_q.size(); i++) begin
            checks++;
            if (ar_obs_q[i] !== ar_exp_q[i]) begin
                $display("CHECK FAILED m_ar beat %0d (%s): expected %h, actual %h",
                         i, label, ar_exp_q[i], ar_obs_q[i]);
                errors++;
            end
        end
    endtask

    task automatic compare_r_beats(input string label);
        if (r_obs_q.size() != r_exp_q.size()) begin
            $display("%s: master side took %0d data beats but %0d were sent",
                     label, r_obs_q.size(), r_exp_q.size());
            errors++;
        end
        for (int i = 0; i < r_exp_q.size() && i < r_obs_q.size(); i++) begin
            checks++;
            if (r_obs_q[i] !== r_exp_q[i]) begin
                $display("CHECK FAILED s_r beat %0d (%s): expected %h, actual %h",
                         i, label, r_exp_q[i], r_obs_q[i]);
                errors++;
            end
        end
    endtask

    task automatic test_ar_stream;
        start_ar_stream(1'b0, 1'b0);
        wait_ar_drain();
        compare_ar_beats("AR stream");
    endtask

    task automatic test_ar_backpressure;
        start_ar_stream(1'b1, 1'b1);
        wait_ar_drain();
        compare_ar_beats("AR back-pressure");
    endtask

    task automatic test_r_stream;
        start_r_stream(1'b0, 1'b0);
        r_full_base  = r_accepts;
        r_full_check = 1'b1;
        wait_r_drain();
        r_full_check = 1'b0;
        compare_r_beats("R full rate");
    endtask

    task automatic test_r_backpressure;
        start_r_stream(1'b1, 1'b1);
        wait_r_drain();
        compare_r_beats("R back-pressure");
    endtask

    task automatic report_and_finish;
        $display("beats compared %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    endtask

    initial begin
        test_reset();
        test_ar_stream();
        test_ar_backpressure();
        test_r_stream();
        test_r_backpressure();
        report_and_finish();
    end

    initial begin
        while (cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
        end
        $display("timeout after %0d cycles, beats still outstanding", cycles);
        errors++;
        report_and_finish();
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+common
common/axi_rd_pkg.sv
src/ar_reg_slice.sv
src/r_skid_slice.sv
src/axi_register_rd.sv
tests/tb_axi_register_rd.sv

/* run_sim.sh */
#!/bin/sh
# build and run the AXI read slice testbench with Verilator
# exit status is zero only when the log holds the pass line

cd "$(dirname "$0")" || exit 1

TOP=tb_axi_register_rd
LOG=sim.log

rm -rf obj_dir "$LOG"

verilator --binary --timing -j 0 --top-module "$TOP" -f compile.f \
    && ./obj_dir/V"$TOP" > "$LOG" 2>&1 \
    || echo "build or simulation stopped with an error"

cat "$LOG" 2>/dev/null

grep -qx "sim passed" "$LOG" 2>/dev/null \
    && { echo "RESULT: PASS"; exit 0; } \
    || { echo "RESULT: FAIL"; exit 1; }
